//--- bridge_pkg.sv
// Shared definitions for the AHB-Lite to DAP bridge
// Address constants, DP/AP register offsets, SELECT banks, error codes
// and the records passed between capture, sequencer and port mux
package bridge_pkg;

   // Local base of the bridge window
   localparam logic [31:0] base_addr = 32'h8000_0000;

   // Fixed upper CSW bits above the size field
   localparam logic [27:0] csw_cfg = 28'hA20_0000;

   // DP register offsets
   localparam logic [1:0] dp_abort_adr  = 2'b00;  // ABORT on write, IDCODE on read
   localparam logic [1:0] dp_select_adr = 2'b10;
   localparam logic [1:0] dp_rdbuff_adr = 2'b11;

   // MEM-AP register offsets inside the selected bank
   localparam logic [1:0] ap_csw_adr = 2'b00;
   localparam logic [1:0] ap_tar_adr = 2'b01;
   localparam logic [1:0] ap_drw_adr = 2'b11;

   // SELECT bank values
   localparam logic [7:0] ap_csw_bank = 8'h00;
   localparam logic [7:0] ap_tar_bank = 8'h04;
   localparam logic [7:0] ap_drw_bank = 8'h0C;
   localparam logic [7:0] ap_bd_bank  = 8'h10;  // BD0-3 picked by addr[3:2]

   // Access size code for a 32-bit word
   localparam logic [1:0] size_word = 2'd2;

   typedef enum logic [2:0] {
      success   = 3'd0,
      fault     = 3'd1,
      timeout   = 3'd2,
      noconnect = 3'd3,
      parity    = 3'd4,
      unknown   = 3'd7
   } err_t;

   // One DP or AP register access
   typedef struct packed {
      logic        apndp;
      logic [1:0]  addr;
      logic        write;
      logic [31:0] data;
   } dap_req_t;

   // Result of a register access
   typedef struct packed {
      logic [31:0] rdata;
      err_t        err;
   } dap_rsp_t;

   // Captured AHB transfer, address already remapped
   typedef struct packed {
      logic [31:0] addr;
      logic        write;
      logic [1:0]  size;
      logic [31:0] wdata;
   } ahb_req_t;

   // Remote address windows
   typedef struct packed {
      logic [7:0][6:0] win32m;   // Upper 7 bits per 32 MB window
      logic [3:0]      win256m;  // Upper 4 bits of the 256 MB window
   } remap_t;

   // Software direct access
   typedef struct packed {
      logic        apndp;
      logic [1:0]  addr;
      logic        write;
      logic [31:0] data;
   } direct_ctrl_t;

endpackage

//--- ahb_capture.sv
`timescale 1ns/10ps
// AHB-Lite slave front end of the bridge
// Takes one transfer at a time, maps it into the remote address space
// and stalls the bus until the MEM-AP sequence reports back
module ahb_capture
(
   input  logic                  CLK,
   input  logic                  RESETn,
   input  logic                  hsel,
   input  logic                  hready,
   input  logic                  hwrite,
   input  logic [1:0]            htrans,
   input  logic [2:0]            hsize,
   input  logic [31:0]           haddr,
   input  logic [31:0]           hwdata,
   input  bridge_pkg::remap_t    remap,
   input  logic                  xfer_done,
   input  logic [31:0]           xfer_rdata,
   input  bridge_pkg::err_t      xfer_err,
   output logic                  hreadyout,
   output logic [31:0]           hrdata,
   output logic                  hresp,
   output logic                  req_pending,
   output bridge_pkg::ahb_req_t  req
);

   logic        take;
   logic [31:0] offset;
   logic [31:0] remote_addr;
   logic        latch_wdata;
   logic        err_first;    // First cycle of ERROR response

   assign take   = hsel && hready && htrans[1];  // NONSEQ or SEQ
   assign offset = haddr - bridge_pkg::base_addr;

   always_comb
   begin
      if (offset[28])
         remote_addr = {remap.win256m, offset[27:0]};
      else
         remote_addr = {remap.win32m[offset[27:25]], offset[24:0]};
   end

   always_ff @(posedge CLK)
   begin
      if (!RESETn)
      begin
         hreadyout   <= 1'b1;
         hresp       <= 1'b0;
         req_pending <= 1'b0;
         latch_wdata <= 1'b0;
         err_first   <= 1'b0;
      end
      else
      begin
         latch_wdata <= 1'b0;
         if (hresp && hreadyout)
            hresp <= 1'b0;     // Second ERROR cycle over
         if (err_first)
         begin
            hreadyout <= 1'b1;
            err_first <= 1'b0;
         end
         if (xfer_done)
         begin
            req_pending <= 1'b0;
            if (xfer_err == bridge_pkg::success)
               hreadyout <= 1'b1;
            else
            begin
               hresp     <= 1'b1;
               err_first <= 1'b1;
            end
         end
         if (take)
         begin
            req_pending <= 1'b1;
            hreadyout   <= 1'b0;
            hresp       <= 1'b0;
            latch_wdata <= hwrite;  // Data phase follows
         end
      end
   end

   always_ff @(posedge CLK)
   begin
      if (take)
      begin
         req.addr  <= remote_addr;
         req.write <= hwrite;
         req.size  <= hsize[1:0];
      end
      if (latch_wdata)
         req.wdata <= hwdata;
      if (xfer_done && !req.write)
         hrdata <= xfer_rdata;
   end

   // Master must see the previous transfer finish before the next one
   a_single_outstanding: assert property (@(posedge CLK) disable iff (!RESETn)
      take |-> !req_pending);

endmodule

//--- mem_ap_sequencer.sv
`timescale 1ns/10ps
// MEM-AP access sequencer
// Breaks a captured AHB transfer into SELECT, CSW, TAR and data register
// accesses, skipping CSW and TAR writes that the caches show are redundant
module mem_ap_sequencer
(
   input  logic                  CLK,
   input  logic                  RESETn,
   input  logic                  req_pending,
   input  bridge_pkg::ahb_req_t  req,
   input  logic [7:0]            apsel,
   input  logic                  seq_done,
   input  bridge_pkg::dap_rsp_t  seq_rsp,
   output logic                  seq_valid,
   output bridge_pkg::dap_req_t  seq_req,
   output logic                  xfer_done,
   output logic [31:0]           xfer_rdata,
   output bridge_pkg::err_t      xfer_err
);

   typedef enum logic [2:0] {
      s_idle,
      s_csw_sel,
      s_csw_wr,
      s_tar_sel,
      s_tar_wr,
      s_data_sel,
      s_data,
      s_rdbuff
   } seq_state_t;

   seq_state_t  state;
   seq_state_t  after_cfg;   // Step after the size check
   logic [1:0]  size_q;      // Size currently in CSW
   logic [31:0] tar_q;       // Value currently in TAR
   logic        tar_valid;
   logic        word_acc;
   logic [31:0] tar_target;
   logic        rsp_err;
   logic [7:0]  sel_bank;

   assign word_acc   = (req.size == bridge_pkg::size_word);
   // Words go through BD0-3, so TAR only needs the 16-byte block
   assign tar_target = word_acc ? {req.addr[31:4], 4'h0} : req.addr;
   assign after_cfg  = (tar_valid && tar_q == tar_target) ? s_data_sel : s_tar_sel;
   assign rsp_err    = (seq_rsp.err != bridge_pkg::success);

   always_comb
   begin
      case (state)
         s_csw_sel: sel_bank = bridge_pkg::ap_csw_bank;
         s_tar_sel: sel_bank = bridge_pkg::ap_tar_bank;
         default:   sel_bank = word_acc ? bridge_pkg::ap_bd_bank : bridge_pkg::ap_drw_bank;
      endcase
   end

   always_comb
   begin
      seq_req = '0;
      case (state)
         s_csw_sel, s_tar_sel, s_data_sel:
         begin
            seq_req.addr  = bridge_pkg::dp_select_adr;
            seq_req.write = 1'b1;
            seq_req.data  = {apsel, 16'h0, sel_bank};
         end
         s_csw_wr:
         begin
            seq_req.apndp = 1'b1;
            seq_req.addr  = bridge_pkg::ap_csw_adr;
            seq_req.write = 1'b1;
            seq_req.data  = {bridge_pkg::csw_cfg, 2'b00, req.size};
         end
         s_tar_wr:
         begin
            seq_req.apndp = 1'b1;
            seq_req.addr  = bridge_pkg::ap_tar_adr;
            seq_req.write = 1'b1;
            seq_req.data  = tar_target;
         end
         s_data:
         begin
            seq_req.apndp = 1'b1;
            seq_req.addr  = word_acc ? req.addr[3:2] : bridge_pkg::ap_drw_adr;
            seq_req.write = req.write;
            seq_req.data  = req.wdata;
         end
         s_rdbuff:
            seq_req.addr = bridge_pkg::dp_rdbuff_adr;  // Posted AP read result
         default:
            seq_req = '0;
      endcase
   end

   always_ff @(posedge CLK)
   begin
      if (!RESETn)
      begin
         state     <= s_idle;
         seq_valid <= 1'b0;
         size_q    <= bridge_pkg::size_word;
         tar_valid <= 1'b0;
         xfer_done <= 1'b0;
         xfer_err  <= bridge_pkg::success;
      end
      else
      begin
         xfer_done <= 1'b0;
         if (state != s_idle && !seq_valid)
            seq_valid <= 1'b1;   // Offer the access of this step
         if (state == s_idle)
         begin
            // req_pending is still high in the cycle of xfer_done
            if (req_pending && !xfer_done)
            begin
               xfer_err <= bridge_pkg::success;
               state    <= (req.size != size_q) ? s_csw_sel : after_cfg;
            end
         end
         else if (seq_done)
         begin
            seq_valid <= 1'b0;
            if (rsp_err)
            begin
               xfer_err  <= seq_rsp.err;
               xfer_done <= 1'b1;
               tar_valid <= 1'b0;  // Remote TAR state unknown
               state     <= s_idle;
            end
            else
            begin
               case (state)
                  s_csw_sel: state <= s_csw_wr;
                  s_csw_wr:
                  begin
                     size_q <= req.size;
                     state  <= after_cfg;
                  end
                  s_tar_sel: state <= s_tar_wr;
                  s_tar_wr:
                  begin
                     tar_q     <= tar_target;
                     tar_valid <= 1'b1;
                     state     <= s_data_sel;
                  end
                  s_data_sel: state <= s_data;
                  s_data:
                  begin
                     if (req.write)
                     begin
                        xfer_done <= 1'b1;
                        state     <= s_idle;
                     end
                     else
                        state <= s_rdbuff;
                  end
                  default:
                  begin
                     xfer_done <= 1'b1;  // RDBUFF holds the read data
                     state     <= s_idle;
                  end
               endcase
            end
         end
      end
   end

   always_ff @(posedge CLK)
   begin
      if (state == s_rdbuff && seq_done)
         xfer_rdata <= seq_rsp.rdata;
   end

   // A completion from the mux answers only the request still raised
   a_done_needs_req: assert property (@(posedge CLK) disable iff (!RESETn)
      seq_done |-> seq_valid);

endmodule

//--- dap_port_mux.sv
`timescale 1ns/10ps
// DAP port arbiter
// Shares the single register-access port between direct software accesses
// and the MEM-AP sequencer, direct requests first, and keeps the error status
module dap_port_mux
(
   input  logic                      CLK,
   input  logic                      RESETn,
   input  logic                      direct_start,
   input  bridge_pkg::direct_ctrl_t  direct_ctrl,
   input  logic                      seq_valid,
   input  bridge_pkg::dap_req_t      seq_req,
   input  logic                      dap_ready,
   input  bridge_pkg::dap_rsp_t      dap_rsp,
   output logic                      direct_busy,
   output logic                      direct_done,
   output logic [31:0]               direct_rdata,
   output bridge_pkg::err_t          stat,
   output logic                      seq_done,
   output bridge_pkg::dap_rsp_t      seq_rsp,
   output logic                      dap_valid,
   output bridge_pkg::dap_req_t      dap_req
);

   typedef enum logic [1:0] {mux_idle, mux_offer, mux_wait} mux_state_t;

   mux_state_t                state;
   logic                      direct_pend;   // Direct access not yet offered
   bridge_pkg::direct_ctrl_t  direct_q;
   logic                      owner_direct;  // Owner of the access in flight
   logic                      ready_q;
   logic                      accept_start;
   logic                      rsp_rise;

   assign accept_start = direct_start && !direct_busy;
   assign rsp_rise     = (state == mux_wait) && dap_ready && !ready_q;

   always_ff @(posedge CLK)
   begin
      if (!RESETn)
      begin
         state        <= mux_idle;
         dap_valid    <= 1'b0;
         direct_busy  <= 1'b0;
         direct_pend  <= 1'b0;
         direct_done  <= 1'b0;
         seq_done     <= 1'b0;
         owner_direct <= 1'b0;
         ready_q      <= 1'b0;
         stat         <= bridge_pkg::success;
      end
      else
      begin
         ready_q     <= dap_ready;
         direct_done <= 1'b0;
         seq_done    <= 1'b0;
         if (accept_start)
         begin
            direct_busy <= 1'b1;
            direct_pend <= 1'b1;
            stat        <= bridge_pkg::success;
         end
         case (state)
            mux_idle:
               if (dap_ready)
               begin
                  if (direct_pend)
                  begin
                     owner_direct <= 1'b1;
                     direct_pend  <= 1'b0;
                     dap_valid    <= 1'b1;
                     state        <= mux_offer;
                  end
                  else if (seq_valid && !seq_done)  // Old request still up on done
                  begin
                     owner_direct <= 1'b0;
                     dap_valid    <= 1'b1;
                     state        <= mux_offer;
                  end
               end
            mux_offer:
               if (dap_ready)
               begin
                  dap_valid <= 1'b0;   // Taken this cycle
                  state     <= mux_wait;
               end
            default:
               if (rsp_rise)
               begin
                  state <= mux_idle;
                  if (dap_rsp.err != bridge_pkg::success)
                     stat <= dap_rsp.err;
                  if (owner_direct)
                  begin
                     direct_done <= 1'b1;
                     direct_busy <= 1'b0;
                  end
                  else
                     seq_done <= 1'b1;
               end
         endcase
      end
   end

   always_ff @(posedge CLK)
   begin
      if (accept_start)
         direct_q <= direct_ctrl;
      if (state == mux_idle && dap_ready)
      begin
         if (direct_pend)
            dap_req <= '{apndp: direct_q.apndp, addr: direct_q.addr,
                         write: direct_q.write, data: direct_q.data};
         else
            dap_req <= seq_req;
      end
      if (rsp_rise && owner_direct)
         direct_rdata <= dap_rsp.rdata;
      if (rsp_rise && !owner_direct)
         seq_rsp <= dap_rsp;
   end

   // Remote keeps ready up until it has taken the offered access
   a_valid_needs_ready: assert property (@(posedge CLK) disable iff (!RESETn)
      dap_valid |-> dap_ready);

endmodule

//--- swd_ahb_bridge.sv
`timescale 1ns/10ps
// AHB-Lite to remote DAP bridge, top level
// AHB capture feeds the MEM-AP sequencer, which shares the DAP
// register port with direct software accesses
module swd_ahb_bridge
(
   input  logic                      CLK,
   input  logic                      RESETn,
   input  logic                      hsel,
   input  logic                      hready,
   input  logic                      hwrite,
   input  logic [1:0]                htrans,
   input  logic [2:0]                hsize,
   input  logic [31:0]               haddr,
   input  logic [31:0]               hwdata,
   output logic                      hreadyout,
   output logic [31:0]               hrdata,
   output logic                      hresp,
   input  bridge_pkg::remap_t        remap,
   input  logic [7:0]                apsel,
   input  logic                      direct_start,
   input  bridge_pkg::direct_ctrl_t  direct_ctrl,
   output logic                      direct_busy,
   output logic                      direct_done,
   output logic [31:0]               direct_rdata,
   output bridge_pkg::err_t          stat,
   output logic                      dap_valid,
   output bridge_pkg::dap_req_t      dap_req,
   input  logic                      dap_ready,
   input  bridge_pkg::dap_rsp_t      dap_rsp
);

   logic                  req_pending;
   bridge_pkg::ahb_req_t  ahb_req;
   logic                  xfer_done;
   logic [31:0]           xfer_rdata;
   bridge_pkg::err_t      xfer_err;
   logic                  seq_valid;
   bridge_pkg::dap_req_t  seq_req;
   logic                  seq_done;
   bridge_pkg::dap_rsp_t  seq_rsp;

   ahb_capture u_capture
   (
      .CLK         (CLK),
      .RESETn      (RESETn),
      .hsel        (hsel),
      .hready      (hready),
      .hwrite      (hwrite),
      .htrans      (htrans),
      .hsize       (hsize),
      .haddr       (haddr),
      .hwdata      (hwdata),
      .remap       (remap),
      .xfer_done   (xfer_done),
      .xfer_rdata  (xfer_rdata),
      .xfer_err    (xfer_err),
      .hreadyout   (hreadyout),
      .hrdata      (hrdata),
      .hresp       (hresp),
      .req_pending (req_pending),
      .req         (ahb_req)
   );

   mem_ap_sequencer u_sequencer
   (
      .CLK         (CLK),
      .RESETn      (RESETn),
      .req_pending (req_pending),
      .req         (ahb_req),
      .apsel       (apsel),
      .seq_done    (seq_done),
      .seq_rsp     (seq_rsp),
      .seq_valid   (seq_valid),
      .seq_req     (seq_req),
      .xfer_done   (xfer_done),
      .xfer_rdata  (xfer_rdata),
      .xfer_err    (xfer_err)
   );

   dap_port_mux u_port_mux
   (
      .CLK          (CLK),
      .RESETn       (RESETn),
      .direct_start (direct_start),
      .direct_ctrl  (direct_ctrl),
      .seq_valid    (seq_valid),
      .seq_req      (seq_req),
      .dap_ready    (dap_ready),
      .dap_rsp      (dap_rsp),
      .direct_busy  (direct_busy),
      .direct_done  (direct_done),
      .direct_rdata (direct_rdata),
      .stat         (stat),
      .seq_done     (seq_done),
      .seq_rsp      (seq_rsp),
      .dap_valid    (dap_valid),
      .dap_req      (dap_req)
   );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/10ps
// Testbench clock and reset source
// 40 ns clock, reset held low for the first 16 rising edges
module tb_clock_gen
(
   output logic CLK,
   output logic RESETn
);

   localparam int half_period = 20;
   localparam int reset_cycles = 16;

   initial
   begin
      CLK = 1'b0;
      forever #(half_period) CLK = ~CLK;
   end

   initial
   begin
      RESETn = 1'b0;
      repeat (reset_cycles) @(posedge CLK);
      #1;
      RESETn = 1'b1;   // Released with the other inputs, after the edge
   end

endmodule

//--- tb_dap_model.sv
`timescale 1ns/10ps
// Behavioral remote DAP for the bridge testbench
// MEM-AP with CSW, TAR, DRW and BD0-3 over a sparse memory, posted AP reads,
// random ready latency and a fault region at the top of the address map
module tb_dap_model
#(
   parameter logic [31:0] idcode = 32'h0BA0_1477
)
(
   input  logic                  CLK,
   input  logic                  RESETn,
   input  logic                  dap_valid,
   input  bridge_pkg::dap_req_t  dap_req,
   output logic                  dap_ready,
   output bridge_pkg::dap_rsp_t  dap_rsp
);

   logic [31:0]           mem [logic [29:0]];
   logic [31:0]           select_q;
   logic [31:0]           csw_q;
   logic [31:0]           tar_q;
   logic [31:0]           posted_q;   // Value of the last AP read
   integer                seed;
   integer                wait_cnt;
   logic                  busy;
   bridge_pkg::dap_rsp_t  rsp_next;

   // Unwritten words read back a pattern built from their address
   function automatic logic [31:0] fill_word(input logic [31:0] adr);
      return {adr[31:2], 2'b00} ^ 32'hC3C3_3C3C;
   endfunction

   task automatic serve(input bridge_pkg::dap_req_t r, output bridge_pkg::dap_rsp_t rsp);
      logic [7:0]  reg_adr;
      logic [31:0] word_adr;
      logic [31:0] mask;
      logic [31:0] cur;
      rsp.rdata = 32'h0;
      rsp.err   = bridge_pkg::success;
      reg_adr   = {select_q[7:4], r.addr, 2'b00};
      // BD0-3 hit a word of the 16-byte TAR block, DRW the exact TAR
      word_adr  = (reg_adr[7:4] == 4'h1) ? {tar_q[31:4], r.addr, 2'b00} : tar_q;
      if (!r.apndp)
      begin
         if (r.write && r.addr == bridge_pkg::dp_select_adr)
            select_q = r.data;
         else if (!r.write && r.addr == 2'b00)
            rsp.rdata = idcode;
         else if (!r.write && r.addr == bridge_pkg::dp_rdbuff_adr)
            rsp.rdata = posted_q;
      end
      else if (reg_adr == 8'h00 || reg_adr == 8'h04)
      begin
         if (r.write && reg_adr == 8'h00)
            csw_q = r.data;
         else if (r.write)
            tar_q = r.data;
         else
         begin
            rsp.rdata = posted_q;
            posted_q  = (reg_adr == 8'h00) ? csw_q : tar_q;
         end
      end
      else if (reg_adr == 8'h0C || reg_adr[7:4] == 4'h1)
      begin
         if (tar_q >= 32'hF000_0000)
            rsp.err = bridge_pkg::fault;   // Nothing mapped up here
         else
         begin
            cur = mem.exists(word_adr[31:2]) ? mem[word_adr[31:2]] : fill_word(word_adr);
            if (reg_adr != 8'h0C || csw_q[2:0] == 3'd2)
               mask = 32'hFFFF_FFFF;
            else if (csw_q[2:0] == 3'd1)
               mask = 32'hFFFF << {tar_q[1], 4'h0};
            else
               mask = 32'hFF << {tar_q[1:0], 3'b000};
            if (r.write)
               mem[word_adr[31:2]] = (cur & ~mask) | (r.data & mask);
            else
            begin
               rsp.rdata = posted_q;   // True value follows in RDBUFF
               posted_q  = cur;
            end
         end
      end
   endtask

   initial
   begin
      seed      = 33;
      busy      = 1'b0;
      wait_cnt  = 0;
      dap_ready = 1'b0;
      dap_rsp   = '0;
      rsp_next  = '0;
      forever
      begin
         @(posedge CLK);
         if (!RESETn)
         begin
            select_q = 32'h0;
            csw_q    = {bridge_pkg::csw_cfg, 4'h2};
            tar_q    = 32'h0;
            posted_q = 32'h0;
            busy     = 1'b0;
            #1;
            dap_ready = 1'b1;
         end
         else if (busy)
         begin
            if (wait_cnt == 0)
            begin
               busy = 1'b0;
               #1;
               dap_rsp   = rsp_next;
               dap_ready = 1'b1;   // Rise marks the result
            end
            else
               wait_cnt = wait_cnt - 1;
         end
         else if (dap_valid && dap_ready)
         begin
            serve(dap_req, rsp_next);
            busy     = 1'b1;
            wait_cnt = $unsigned($random(seed)) % 4;
            #1;
            dap_ready = 1'b0;
         end
      end
   end

endmodule

//--- tb_bridge.sv
`timescale 1ns/10ps
// Testbench for the AHB-Lite to DAP bridge
// Runs AHB transfers and direct accesses against a behavioral DAP and
// checks read data against a shadow copy of remote memory
module tb_bridge;

   localparam logic [31:0] dap_idcode = 32'h0BA0_1477;
   // About 100 transfers, each up to 8 DAP accesses of at most 9 cycles, plus margin
   localparam int max_cycles = 20000;

   logic                      CLK;
   logic                      RESETn;
   logic                      hsel;
   logic                      hready;
   logic                      hwrite;
   logic [1:0]                htrans;
   logic [2:0]                hsize;
   logic [31:0]               haddr;
   logic [31:0]               hwdata;
   logic                      hreadyout;
   logic [31:0]               hrdata;
   logic                      hresp;
   bridge_pkg::remap_t        remap;
   logic [7:0]                apsel;
   logic                      direct_start;
   bridge_pkg::direct_ctrl_t  direct_ctrl;
   logic                      direct_busy;
   logic                      direct_done;
   logic [31:0]               direct_rdata;
   bridge_pkg::err_t          stat;
   logic                      dap_valid;
   bridge_pkg::dap_req_t      dap_req;
   logic                      dap_ready;
   bridge_pkg::dap_rsp_t      dap_rsp;

   logic [31:0] shadow [logic [29:0]];   // Expected remote memory, by word
   string       test_name;
   integer      seed;
   int          cycles = 0;
   logic        rd_expect;                // OKAY read in flight with known data
   logic [31:0] rd_expected;
   logic [31:0] dir_expected;
   logic [31:0] addr_list [12];

   tb_clock_gen u_clock (.CLK(CLK), .RESETn(RESETn));

   swd_ahb_bridge swd_ahb_bridge_inst (.*);

   tb_dap_model #(.idcode(dap_idcode)) u_dap (.*);

   task automatic report_fail(input string what);
      $display("%s", what);
      $display("** FAIL **");
      $fatal(1);
   endtask

   task automatic check_stat(input bridge_pkg::err_t exp);
      assert (stat == exp)
      else
         report_fail($sformatf("Mismatch %s: stat expected %0d, actual %0d",
                               test_name, exp, stat));
   endtask

   // Local address to remote address through the remap windows
   function automatic logic [31:0] remote_of(input logic [31:0] local_addr);
      logic [31:0] off;
      off = local_addr - bridge_pkg::base_addr;
      if (off[28])
         return {remap.win256m, off[27:0]};
      return {remap.win32m[off[27:25]], off[24:0]};
   endfunction

   // Byte lanes touched by a write replace those of the old word
   function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                               input logic [31:0] data,
                                               input logic [1:0] size,
                                               input logic [1:0] lane);
      logic [31:0] result;
      int          lo;
      int          nbytes;
      result = old_word;
      lo     = int'(lane);
      nbytes = (size == 2'd0) ? 1 : ((size == 2'd1) ? 2 : 4);
      for (int b = 0; b < 4; b++)
      begin
         if (b >= lo && b < lo + nbytes)
            result[8*b +: 8] = data[8*b +: 8];
      end
      return result;
   endfunction

   task automatic ahb_xfer(input logic wr, input logic [2:0] size, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic check,
                           input logic [31:0] exp, output logic err);
      logic first_seen;
      first_seen = 1'b0;
      hsel   = 1'b1;
      htrans = 2'b10;   // NONSEQ
      hwrite = wr;
      hsize  = size;
      haddr  = addr;
      @(posedge CLK);
      #1;
      hsel        = 1'b0;
      htrans      = 2'b00;
      hwdata      = wdata;
      rd_expected = exp;
      rd_expect   = check;
      do
      begin
         @(posedge CLK);
         if (hresp && !hreadyout)
            first_seen = 1'b1;
      end
      while (!hreadyout);
      err = hresp;
      assert (!hresp || first_seen)
      else
         report_fail($sformatf("%s: ERROR response lacked its first cycle", test_name));
      #1;
      rd_expect = 1'b0;
   endtask

   task automatic ahb_write(input logic [31:0] addr, input logic [2:0] size,
                            input logic [31:0] data);
      logic [31:0] remote;
      logic [31:0] old_word;
      logic        err;
      remote = remote_of(addr);
      ahb_xfer(1'b1, size, addr, data, 1'b0, 32'h0, err);
      assert (!err)
      else
         report_fail($sformatf("%s: write to %h ended with ERROR", test_name, addr));
      old_word = shadow.exists(remote[31:2]) ? shadow[remote[31:2]] : 32'h0;
      shadow[remote[31:2]] = merge_lanes(old_word, data, size[1:0], remote[1:0]);
   endtask

   task automatic ahb_read_check(input logic [31:0] addr);
      logic [31:0] remote;
      logic        err;
      remote = remote_of(addr);
      ahb_xfer(1'b0, 3'd2, addr, 32'h0, 1'b1, shadow[remote[31:2]], err);
      assert (!err)
      else
         report_fail($sformatf("%s: read of %h ended with ERROR", test_name, addr));
   endtask

   task automatic direct_read(input logic [1:0] adr, input logic [31:0] exp);
      direct_ctrl.apndp = 1'b0;
      direct_ctrl.addr  = adr;
      direct_ctrl.write = 1'b0;
      direct_ctrl.data  = 32'h0;
      dir_expected      = exp;
      direct_start      = 1'b1;
      @(posedge CLK);
      #1;
      direct_start = 1'b0;
      assert (direct_busy)
      else
         report_fail($sformatf("%s: direct_busy did not rise after the start", test_name));
      do
         @(posedge CLK);
      while (!direct_done);
      #1;
      assert (!direct_busy)
      else
         report_fail($sformatf("%s: direct_busy still high after direct_done", test_name));
   endtask

   // Compare process
   always @(posedge CLK)
   begin
      if (rd_expect && hreadyout && !hresp)
      begin
         assert (hrdata == rd_expected)
         else
            report_fail($sformatf("Mismatch %s: expected %h, actual %h",
                                  test_name, rd_expected, hrdata));
      end
      if (direct_done)
      begin
         assert (direct_rdata == dir_expected)
         else
            report_fail($sformatf("Mismatch %s: expected %h, actual %h",
                                  test_name, dir_expected, direct_rdata));
      end
   end

   always @(posedge CLK)
   begin
      cycles = cycles + 1;
      if (cycles >= max_cycles)
         report_fail($sformatf("Timeout in %s after %0d cycles", test_name, cycles));
   end

   initial
   begin
      int          i;
      int          w;
      int          lane;
      logic [31:0] a;
      logic [31:0] d;
      logic        err;
      seed         = 33;
      test_name    = "reset";
      hsel         = 1'b0;
      hready       = 1'b1;
      hwrite       = 1'b0;
      htrans       = 2'b00;
      hsize        = 3'd0;
      haddr        = 32'h0;
      hwdata       = 32'h0;
      apsel        = 8'h00;
      direct_start = 1'b0;
      direct_ctrl  = '0;
      rd_expect    = 1'b0;
      rd_expected  = 32'h0;
      dir_expected = 32'h0;
      for (int k = 0; k < 7; k++)
         remap.win32m[k] = 7'(16 + k);   // Remote 0x2000_0000 upward
      remap.win32m[7] = 7'h7F;          // Lands in the faulting region
      remap.win256m   = 4'h4;
      wait (RESETn);
      @(posedge CLK);
      #1;

      test_name = "direct_idcode";
      direct_read(bridge_pkg::dp_abort_adr, dap_idcode);
      check_stat(bridge_pkg::success);

      test_name = "word_windows";
      for (i = 0; i < 12; i++)
      begin
         d = $random(seed);
         if (i % 4 == 3)
            a = bridge_pkg::base_addr + 32'h1000_0000 + ({$random(seed)} & 32'h0FFF_FFFC);
         else
            a = bridge_pkg::base_addr + {4'h0, 3'(i % 7), 25'h0}
                + ({$random(seed)} & 32'h01FF_FFFC);
         addr_list[i] = a;
         ahb_write(a, 3'd2, d);
         ahb_read_check(a);
      end
      for (i = 11; i >= 0; i--)
         ahb_read_check(addr_list[i]);

      test_name = "byte_half_lanes";
      a = bridge_pkg::base_addr + {4'h0, 3'd2, 25'h0} + 32'h0000_4000;
      for (i = 0; i < 4; i++)
      begin
         d = $random(seed);
         ahb_write(a + 32'(4 * i), 3'd2, d);
      end
      for (i = 0; i < 16; i++)
      begin
         d    = $random(seed);
         w    = i / 4;
         lane = i % 4;
         if ((w + lane) % 3 != 0)   // Leave some lanes untouched
         begin
            if (w % 2 == 0)
               ahb_write(a + 32'(4 * w + lane), 3'd0, d);
            else if (lane % 2 == 0)
               ahb_write(a + 32'(4 * w + lane), 3'd1, d);
         end
      end
      for (i = 0; i < 4; i++)
         ahb_read_check(a + 32'(4 * i));

      test_name = "direct_during_ahb";
      fork
         begin
            for (i = 0; i < 4; i++)
            begin
               a = bridge_pkg::base_addr + {4'h0, 3'd4, 25'h0} + 32'(16 * i);
               d = $random(seed);
               ahb_write(a, 3'd2, d);
               ahb_read_check(a);
            end
         end
         begin
            repeat (6) @(posedge CLK);
            #1;
            direct_read(bridge_pkg::dp_abort_adr, dap_idcode);
         end
      join

      test_name = "fault_window";
      a = bridge_pkg::base_addr + {4'h0, 3'd7, 25'h0} + 32'h100;
      ahb_xfer(1'b1, 3'd2, a, 32'h1234_5678, 1'b0, 32'h0, err);
      assert (err)
      else
         report_fail($sformatf("%s: write to %h gave no ERROR response", test_name, a));
      check_stat(bridge_pkg::fault);
      ahb_xfer(1'b0, 3'd2, a, 32'h0, 1'b0, 32'h0, err);
      assert (err)
      else
         report_fail($sformatf("%s: read of %h gave no ERROR response", test_name, a));
      a = bridge_pkg::base_addr + {4'h0, 3'd1, 25'h0} + 32'h80;
      d = $random(seed);
      ahb_write(a, 3'd2, d);
      ahb_read_check(a);
      direct_read(bridge_pkg::dp_abort_adr, dap_idcode);
      check_stat(bridge_pkg::success);

      $display("** PASS **");
      $finish;
   end

endmodule

//--- compile.f
bridge_pkg.sv
ahb_capture.sv
mem_ap_sequencer.sv
dap_port_mux.sv
swd_ahb_bridge.sv
tb_clock_gen.sv
tb_dap_model.sv
tb_bridge.sv

//--- run.sh
#!/bin/sh
# Build the bridge testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module tb_bridge -f compile.f -o tb_bridge_sim
result=$(./obj_dir/tb_bridge_sim 2>&1 || true)
printf '%s\n' "$result"
if printf '%s\n' "$result" | grep -q -F '** PASS **'; then
   exit 0
fi
exit 1
